// File: src/fifo_cfg_pkg.sv
/* FIFO storage geometry shared by the flop RAM, both controllers and the testbench */

`default_nettype none

package fifo_cfg_pkg;

  // --------------------
  // Storage geometry
  // --------------------

  // Number of entries held in the flop RAM
  localparam int fifo_depth = 8;

  // Bits carried by each entry
  localparam int fifo_width = 16;

  // --------------------
  // Derived widths
  // --------------------

  // Pointer width into the RAM, one bit per power of two of the depth
  localparam int addr_width = $clog2(fifo_depth);

  // Counts span 0 through fifo_depth inclusive, so one value more than the
  // pointer range has to fit
  localparam int count_width = $clog2(fifo_depth + 1);

  // Largest valid pointer value, used for wrap-around in both controllers
  localparam int last_addr = fifo_depth - 1;

  // Buffer depth as a count value, used for full and slots
  localparam int depth_count = fifo_depth;

endpackage : fifo_cfg_pkg

`default_nettype wire

// File: src/credit_pkg.sv
/* Credit counter sizing and pop output stage state encoding */

`default_nettype none

package credit_pkg;

  import fifo_cfg_pkg::*;

  // --------------------
  // Credit sizing
  // --------------------

  // The receiver never hands out more credit than there are entries
  localparam int max_credit = fifo_depth;

  // Counter holds 0 through max_credit
  localparam int credit_width = $clog2(max_credit + 1);

  // State of the pop output register
  // POP_EMPTY means the register holds nothing, POP_HOLD means pop_valid is up
  typedef enum logic [1:0] {
    POP_EMPTY = 2'd0,
    POP_HOLD  = 2'd1
  } pop_state_t;

endpackage : credit_pkg

`default_nettype wire

// File: src/ram_flops_1r1w.sv
/* Flop array with one write port and one combinational read port */

`default_nettype none
`timescale 1ns/100ps

module ram_flops_1r1w (
  input  wire logic                            clk,
  input  wire logic                            wr_valid,
  input  wire logic [fifo_cfg_pkg::addr_width-1:0] wr_addr,
  input  wire logic [fifo_cfg_pkg::fifo_width-1:0] wr_data,
  input  wire logic [fifo_cfg_pkg::addr_width-1:0] rd_addr,
  output logic      [fifo_cfg_pkg::fifo_width-1:0] rd_data
);

  import fifo_cfg_pkg::*;

  // --------------------
  // Storage
  // --------------------

  // One register per entry
  // Cells are only read after the FIFO has written them, so they carry no reset
  logic [fifo_width-1:0] mem [fifo_depth];

  // Write happens at the clock edge that ends the push cycle
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // Zero read latency
  // The pop controller samples rd_data into its output register in the
  // same cycle it presents rd_addr
  always_comb begin
    rd_data = mem[rd_addr];
  end

  // The FIFO never reads the slot it is writing in the same cycle, because an
  // entry only becomes visible to the reader one edge after it is written, so
  // no write-to-read bypass is needed here

endmodule : ram_flops_1r1w

`default_nettype wire

// File: src/fifo_push_credit_ctrl.sv
/* Push side of the FIFO with the credit counter, write pointer and the occupancy
   counts behind ram_has_data and the status flags */

`default_nettype none
`timescale 1ns/100ps

module fifo_push_credit_ctrl (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                push_credit_stall,
  output logic                                     push_credit,
  input  wire logic                                push_valid,
  input  wire logic [fifo_cfg_pkg::fifo_width-1:0]   push_data,
  input  wire logic [credit_pkg::credit_width-1:0]   credit_initial_push,
  input  wire logic [credit_pkg::credit_width-1:0]   credit_withhold_push,
  output logic      [credit_pkg::credit_width-1:0]   credit_count_push,
  output logic      [credit_pkg::credit_width-1:0]   credit_available_push,
  input  wire logic                                pop_taken,
  input  wire logic                                ram_read_taken,
  output logic                                     ram_has_data,
  output logic                                     ram_wr_valid,
  output logic      [fifo_cfg_pkg::addr_width-1:0]   ram_wr_addr,
  output logic      [fifo_cfg_pkg::fifo_width-1:0]   ram_wr_data,
  output logic                                     full,
  output logic      [fifo_cfg_pkg::count_width-1:0]  slots,
  output logic                                     empty,
  output logic      [fifo_cfg_pkg::count_width-1:0]  items
);

  import fifo_cfg_pkg::*;
  import credit_pkg::*;

  logic                   credit_active;
  logic [addr_width-1:0]  wr_ptr;
  logic [count_width-1:0] ram_count;

  // --------------------
  // Credit counter
  // --------------------

  // Held low through reset and for the first edge after it, so the counter
  // has loaded credit_initial_push before any credit goes out
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_active <= 1'b0;
    end else begin
      credit_active <= 1'b1;
    end
  end

  // Withheld credit stays in the count but cannot be granted
  always_comb begin
    if (credit_count_push > credit_withhold_push) begin
      credit_available_push = credit_count_push - credit_withhold_push;
    end else begin
      credit_available_push = '0;
    end
  end

  // One credit per cycle while any is available and the receiver is not stalled
  assign push_credit = credit_active && !push_credit_stall && (credit_available_push != '0);

  // A pop returns a credit at the edge ending its cycle, so the credit is
  // usable one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count_push <= credit_initial_push;
    end else begin
      case ({pop_taken, push_credit})
        2'b10:   credit_count_push <= credit_count_push + 1'b1;
        2'b01:   credit_count_push <= credit_count_push - 1'b1;
        default: credit_count_push <= credit_count_push;
      endcase
    end
  end

  // --------------------
  // RAM write
  // --------------------

  // Every push_valid cycle is accepted, the sender guarantees it held a credit
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_valid) begin
      wr_ptr <= (wr_ptr == addr_width'(last_addr)) ? '0 : wr_ptr + 1'b1;
    end
  end

  // --------------------
  // Occupancy
  // --------------------

  // Entries written to the RAM but not yet moved into the pop register
  always_ff @(posedge clk) begin
    if (rst) begin
      ram_count <= '0;
    end else begin
      case ({push_valid, ram_read_taken})
        2'b10:   ram_count <= ram_count + 1'b1;
        2'b01:   ram_count <= ram_count - 1'b1;
        default: ram_count <= ram_count;
      endcase
    end
  end

  // Registered count, so a fresh push is seen by the reader one cycle later
  assign ram_has_data = (ram_count != '0);

  // Items covers the RAM plus the pop output register
  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else begin
      case ({push_valid, pop_taken})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

  assign slots = count_width'(depth_count) - items;
  assign full  = (items == count_width'(depth_count));
  assign empty = (items == '0);

endmodule : fifo_push_credit_ctrl

`default_nettype wire

// File: src/fifo_pop_ctrl.sv
/* Pop side of the FIFO, a read pointer feeding a registered ready-valid output stage */

`default_nettype none
`timescale 1ns/100ps

module fifo_pop_ctrl (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                ram_has_data,
  output logic      [fifo_cfg_pkg::addr_width-1:0]   ram_rd_addr,
  input  wire logic [fifo_cfg_pkg::fifo_width-1:0]   ram_rd_data,
  output logic                                     ram_read_taken,
  output logic                                     pop_taken,
  input  wire logic                                pop_ready,
  output logic                                     pop_valid,
  output logic      [fifo_cfg_pkg::fifo_width-1:0]   pop_data
);

  import fifo_cfg_pkg::*;
  import credit_pkg::*;

  pop_state_t            state;
  pop_state_t            state_next;
  logic [addr_width-1:0] rd_ptr;
  logic                  load;

  // --------------------
  // Handshake
  // --------------------

  assign pop_valid = (state == POP_HOLD);
  assign pop_taken = pop_valid && pop_ready;

  // The register takes the RAM head when it is empty or emptying this cycle
  assign load           = ((state == POP_EMPTY) || pop_taken) && ram_has_data;
  assign ram_read_taken = load;

  // The read pointer always sits on the oldest unread entry
  assign ram_rd_addr = rd_ptr;

  // --------------------
  // State machine
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      POP_EMPTY: begin
        if (load) begin
          state_next = POP_HOLD;
        end
      end
      POP_HOLD: begin
        // A transfer with nothing behind it drains the register
        if (pop_taken && !load) begin
          state_next = POP_EMPTY;
        end
      end
      default: begin
        state_next = POP_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= POP_EMPTY;
    end else begin
      state <= state_next;
    end
  end

  // Advance past the entry just copied out
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (load) begin
      rd_ptr <= (rd_ptr == addr_width'(last_addr)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // --------------------
  // Output register
  // --------------------

  // Payload only, pop_valid qualifies it
  // Without a load the value is held, which keeps pop_data stable under
  // back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      pop_data <= ram_rd_data;
    end
  end

endmodule : fifo_pop_ctrl

`default_nettype wire

// File: src/fifo_flops_push_credit.sv
/* FIFO with credit-valid push, ready-valid pop and an internal flop RAM */

`default_nettype none
`timescale 1ns/100ps

module fifo_flops_push_credit (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                push_sender_in_reset,
  output logic                                     push_receiver_in_reset,
  input  wire logic                                push_credit_stall,
  output logic                                     push_credit,
  input  wire logic                                push_valid,
  input  wire logic [fifo_cfg_pkg::fifo_width-1:0]   push_data,
  input  wire logic                                pop_ready,
  output logic                                     pop_valid,
  output logic      [fifo_cfg_pkg::fifo_width-1:0]   pop_data,
  output logic                                     full,
  output logic      [fifo_cfg_pkg::count_width-1:0]  slots,
  input  wire logic [credit_pkg::credit_width-1:0]   credit_initial_push,
  input  wire logic [credit_pkg::credit_width-1:0]   credit_withhold_push,
  output logic      [credit_pkg::credit_width-1:0]   credit_count_push,
  output logic      [credit_pkg::credit_width-1:0]   credit_available_push,
  output logic                                     empty,
  output logic      [fifo_cfg_pkg::count_width-1:0]  items
);

  import fifo_cfg_pkg::*;

  logic                  either_rst;
  logic                  ram_wr_valid;
  logic [addr_width-1:0] ram_wr_addr;
  logic [fifo_width-1:0] ram_wr_data;
  logic [addr_width-1:0] ram_rd_addr;
  logic [fifo_width-1:0] ram_rd_data;
  logic                  ram_has_data;
  logic                  ram_read_taken;
  logic                  pop_taken;

  // --------------------
  // Reset handling
  // --------------------

  // A sender reset drops all buffered entries and reloads the credit count
  assign either_rst = rst || push_sender_in_reset;

  // Tells the sender our reset state one cycle late
  always_ff @(posedge clk) begin
    push_receiver_in_reset <= rst;
  end

  // --------------------
  // Blocks
  // --------------------

  fifo_push_credit_ctrl u_push_ctrl (
    .clk                   (clk),
    .rst                   (either_rst),
    .push_credit_stall     (push_credit_stall),
    .push_credit           (push_credit),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .credit_initial_push   (credit_initial_push),
    .credit_withhold_push  (credit_withhold_push),
    .credit_count_push     (credit_count_push),
    .credit_available_push (credit_available_push),
    .pop_taken             (pop_taken),
    .ram_read_taken        (ram_read_taken),
    .ram_has_data          (ram_has_data),
    .ram_wr_valid          (ram_wr_valid),
    .ram_wr_addr           (ram_wr_addr),
    .ram_wr_data           (ram_wr_data),
    .full                  (full),
    .slots                 (slots),
    .empty                 (empty),
    .items                 (items)
  );

  fifo_pop_ctrl u_pop_ctrl (
    .clk            (clk),
    .rst            (either_rst),
    .ram_has_data   (ram_has_data),
    .ram_rd_addr    (ram_rd_addr),
    .ram_rd_data    (ram_rd_data),
    .ram_read_taken (ram_read_taken),
    .pop_taken      (pop_taken),
    .pop_ready      (pop_ready),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data)
  );

  // Storage has no reset, both pointers are cleared by either_rst instead
  ram_flops_1r1w u_ram (
    .clk      (clk),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_addr  (ram_rd_addr),
    .rd_data  (ram_rd_data)
  );

endmodule : fifo_flops_push_credit

`default_nettype wire

// File: tb/tb_fifo_flops_push_credit.sv
/* Testbench for the credit-valid push, ready-valid pop FIFO
   Table-driven stimulus with a sender credit model and a reference queue */

`default_nettype none
`timescale 1ns/100ps

module tb_fifo_flops_push_credit;

  import fifo_cfg_pkg::*;
  import credit_pkg::*;

  // One row of the stimulus table
  // ready_mode 0 holds pop_ready low, 1 holds it high, 2 draws it from the LFSR
  typedef struct packed {
    logic [7:0]              cycles;
    logic                    push_en;
    logic [1:0]              ready_mode;
    logic                    stall;
    logic [credit_width-1:0] withhold;
    logic                    sender_rst;
  } step_t;

  logic                    clk;
  logic                    rst;
  logic                    push_sender_in_reset;
  logic                    push_receiver_in_reset;
  logic                    push_credit_stall;
  logic                    push_credit;
  logic                    push_valid;
  logic [fifo_width-1:0]   push_data;
  logic                    pop_ready;
  logic                    pop_valid;
  logic [fifo_width-1:0]   pop_data;
  logic                    full;
  logic [count_width-1:0]  slots;
  logic [credit_width-1:0] credit_initial_push;
  logic [credit_width-1:0] credit_withhold_push;
  logic [credit_width-1:0] credit_count_push;
  logic [credit_width-1:0] credit_available_push;
  logic                    empty;
  logic [count_width-1:0]  items;

  step_t                 steps[$];
  logic [fifo_width-1:0] ref_q[$];
  logic [15:0]           lfsr_state;
  logic [fifo_width-1:0] hold_data;
  logic                  hold_pending;
  logic                  credit_live;
  logic                  rst_prev;
  logic                  full_seen;
  int                    held;
  int                    credits_rx;
  int                    pops;
  int                    pops_total;
  int                    bound;
  int                    bound_withhold;
  int                    cycle_count = 0;
  int                    cycle_limit = 0;

  fifo_flops_push_credit UUT (
    .clk                    (clk),
    .rst                    (rst),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_receiver_in_reset (push_receiver_in_reset),
    .push_credit_stall      (push_credit_stall),
    .push_credit            (push_credit),
    .push_valid             (push_valid),
    .push_data              (push_data),
    .pop_ready              (pop_ready),
    .pop_valid              (pop_valid),
    .pop_data               (pop_data),
    .full                   (full),
    .slots                  (slots),
    .credit_initial_push    (credit_initial_push),
    .credit_withhold_push   (credit_withhold_push),
    .credit_count_push      (credit_count_push),
    .credit_available_push  (credit_available_push),
    .empty                  (empty),
    .items                  (items)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR, one shift per bit taken
  function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  task automatic next_lfsr_bit(output logic bit_out);
    bit_out    = lfsr_state[0];
    lfsr_state = lfsr_advance(lfsr_state);
  endtask

  task automatic make_push_data(output logic [fifo_width-1:0] data);
    logic b;
    int   i;
    data = '0;
    for (i = 0; i < fifo_width; i++) begin
      next_lfsr_bit(b);
      data = {data[fifo_width-2:0], b};
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("[FAIL] %s actual 0x%0h expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic add_step(input logic [7:0] cycles, input logic push_en,
                          input logic [1:0] ready_mode, input logic stall,
                          input logic [credit_width-1:0] withhold, input logic sender_rst);
    step_t s;
    s.cycles     = cycles;
    s.push_en    = push_en;
    s.ready_mode = ready_mode;
    s.stall      = stall;
    s.withhold   = withhold;
    s.sender_rst = sender_rst;
    steps.push_back(s);
  endtask

  // --------------------
  // Sender and checks
  // --------------------

  // The sender pushes only while it holds a credit it has not spent
  task automatic drive_step(input step_t s);
    logic                  do_push;
    logic                  ready;
    logic [fifo_width-1:0] data;
    do_push = s.push_en && !s.sender_rst && (held > 0);
    data    = '0;
    if (do_push) begin
      make_push_data(data);
    end
    if (s.ready_mode == 2'd2) begin
      next_lfsr_bit(ready);
    end else begin
      ready = s.ready_mode[0];
    end
    push_valid           <= do_push;
    push_data            <= data;
    pop_ready            <= ready;
    push_credit_stall    <= s.stall;
    credit_withhold_push <= s.withhold;
    push_sender_in_reset <= s.sender_rst;
  endtask

  // Runs mid-cycle, checks the state left by earlier cycles, then books this cycle's events
  task automatic sample_cycle();
    int                    exp_count;
    int                    exp_avail;
    logic                  exp_credit;
    logic [fifo_width-1:0] head;
    // The count starts at the initial credit, gains one per pop, loses one per grant
    exp_count = int'(credit_initial_push) + pops - credits_rx;
    if (exp_count > int'(credit_withhold_push)) begin
      exp_avail = exp_count - int'(credit_withhold_push);
    end else begin
      exp_avail = 0;
    end
    exp_credit = credit_live && !push_credit_stall && (exp_avail != 0);
    compare_value("credit_count_push", 32'(credit_count_push), exp_count);
    compare_value("credit_available_push", 32'(credit_available_push), exp_avail);
    compare_value("push_credit", 32'(push_credit), 32'(exp_credit));
    compare_value("push_receiver_in_reset", 32'(push_receiver_in_reset), 32'(rst_prev));
    compare_value("items", 32'(items), ref_q.size());
    compare_value("slots", 32'(slots), fifo_depth - ref_q.size());
    compare_value("full", 32'(full), 32'(ref_q.size() == fifo_depth));
    compare_value("empty", 32'(empty), 32'(ref_q.size() == 0));
    if (ref_q.size() == 0) begin
      compare_value("pop_valid", 32'(pop_valid), 32'd0);
    end
    // A stalled output keeps its entry
    if (hold_pending) begin
      compare_value("pop_valid", 32'(pop_valid), 32'd1);
      compare_value("pop_data", 32'(pop_data), 32'(hold_data));
    end
    // A new withhold only sets a bound once the buffer and the sender have drained
    if (int'(credit_withhold_push) != bound_withhold) begin
      bound          = fifo_depth;
      bound_withhold = int'(credit_withhold_push);
    end
    compare_value("items_bound", 32'(ref_q.size() <= bound), 32'd1);
    if (pop_valid && pop_ready) begin
      head = ref_q.pop_front();
      compare_value("pop_data", 32'(pop_data), 32'(head));
      pops       = pops + 1;
      pops_total = pops_total + 1;
    end
    if (push_valid) begin
      ref_q.push_back(push_data);
      held = held - 1;
    end
    if (push_credit) begin
      held       = held + 1;
      credits_rx = credits_rx + 1;
    end
    hold_pending = pop_valid && !pop_ready;
    hold_data    = pop_data;
    if (full) begin
      full_seen = 1'b1;
    end
    // Sender reset empties the FIFO and reloads the credit count at this edge
    if (push_sender_in_reset) begin
      ref_q.delete();
      held         = 0;
      credits_rx   = 0;
      pops         = 0;
      hold_pending = 1'b0;
      credit_live  = 1'b0;
    end else begin
      credit_live = 1'b1;
    end
    rst_prev = rst;
    if ((ref_q.size() == 0) && (held == 0)) begin
      bound = fifo_depth - int'(credit_withhold_push);
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    int i;
    int n;
    rst                  = 1'b1;
    push_sender_in_reset = 1'b0;
    push_credit_stall    = 1'b0;
    push_valid           = 1'b0;
    push_data            = '0;
    pop_ready            = 1'b0;
    credit_initial_push  = credit_width'(fifo_depth);
    credit_withhold_push = '0;
    lfsr_state     = 16'd48;
    hold_pending   = 1'b0;
    hold_data      = '0;
    credit_live    = 1'b0;
    rst_prev       = 1'b1;
    full_seen      = 1'b0;
    held           = 0;
    credits_rx     = 0;
    pops           = 0;
    pops_total     = 0;
    bound          = fifo_depth;
    bound_withhold = 0;

    // cycles, push enable, ready mode, stall, withhold, sender reset
    add_step(8'd24, 1'b1, 2'd1, 1'b0, 4'd0, 1'b0);
    add_step(8'd30, 1'b1, 2'd0, 1'b0, 4'd0, 1'b0);
    add_step(8'd30, 1'b1, 2'd1, 1'b0, 4'd0, 1'b0);
    add_step(8'd12, 1'b1, 2'd1, 1'b1, 4'd0, 1'b0);
    add_step(8'd20, 1'b0, 2'd1, 1'b0, 4'd0, 1'b0);
    add_step(8'd10, 1'b1, 2'd0, 1'b0, 4'd2, 1'b0);
    add_step(8'd3,  1'b0, 2'd1, 1'b0, 4'd3, 1'b1);
    add_step(8'd24, 1'b1, 2'd0, 1'b0, 4'd3, 1'b0);
    add_step(8'd20, 1'b1, 2'd1, 1'b0, 4'd3, 1'b0);
    add_step(8'd40, 1'b1, 2'd2, 1'b0, 4'd0, 1'b0);
    add_step(8'd30, 1'b0, 2'd1, 1'b0, 4'd0, 1'b0);

    cycle_limit = 100;
    for (i = 0; i < steps.size(); i++) begin
      cycle_limit = cycle_limit + int'(steps[i].cycles);
    end

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_value("pop_valid", 32'(pop_valid), 32'd0);
    compare_value("empty", 32'(empty), 32'd1);
    sample_cycle();

    for (i = 0; i < steps.size(); i++) begin
      for (n = 0; n < int'(steps[i].cycles); n++) begin
        @(posedge clk);
        drive_step(steps[i]);
        @(negedge clk);
        sample_cycle();
      end
    end

    compare_value("queue_drained", ref_q.size(), 32'd0);
    compare_value("full_seen", 32'(full_seen), 32'd1);
    compare_value("pops_seen", 32'(pops_total > 0), 32'd1);
    $display("TEST PASS");
    $finish;
  end

  // Run limit from the table length plus a margin
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_on_error($sformatf("Timeout: run went past %0d cycles", cycle_limit));
    end
  end

endmodule : tb_fifo_flops_push_credit

`default_nettype wire

// File: sources.f
src/fifo_cfg_pkg.sv
src/credit_pkg.sv
src/ram_flops_1r1w.sv
src/fifo_push_credit_ctrl.sv
src/fifo_pop_ctrl.sv
src/fifo_flops_push_credit.sv
tb/tb_fifo_flops_push_credit.sv

// File: Makefile
# Verilator build and run for the credit FIFO testbench

VERILATOR  ?= verilator
TOP        ?= tb_fifo_flops_push_credit
RTL_TOP    ?= fifo_flops_push_credit
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST PASS
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

RTL_SRCS := $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
